// File: design/ternary_pkg.sv
// ====================
// shared sizes, widths and operand types for the ternary matmul engine
// every design file refers to these by scoped names
// ====================

package ternary_pkg;

    // one operand group spans this many cycles, one array column per cycle
    localparam int slices = 4;

    // base-3 digits carried by one 8-bit weight code (3^5 = 243 <= 256)
    localparam int trits_per_byte = 5;

    // array geometry
    localparam int rows = slices * trits_per_byte;
    localparam int cols = slices;
    localparam int cells = rows * cols;

    // datapath widths
    localparam int act_width = 8;
    localparam int acc_width = 17;

    // low bit of the output byte taken from a queue entry
    localparam int out_shift = 8;

    // slice counter, 0 to slices-1
    typedef logic [$clog2(slices)-1:0] slice_idx_t;

    // readout index over all cells, row times cols plus column
    typedef logic [$clog2(cells)-1:0] cell_idx_t;

    // one decoded code
    // bit 4-k holds the weight of digit k
    typedef struct packed {
        logic [trits_per_byte-1:0] zero;
        logic [trits_per_byte-1:0] sign;
    } trit_group_t;

    // row weights of one complete group
    // rows 5s to 5s+4 come from slice s
    typedef struct packed {
        logic [rows-1:0] zero;
        logic [rows-1:0] sign;
    } weight_vec_t;

    // one activation per column, each read back as signed
    typedef logic [cols-1:0][act_width-1:0] act_vec_t;

    // signed accumulator cell
    typedef logic signed [acc_width-1:0] acc_t;

endpackage

// File: design/ternary_trit_decoder.sv
// ====================
// combinational unpacker of one 8-bit code into five ternary weights
// digit 0 -> 0, digit 1 -> +1, digit 2 -> -1; codes past 242 give all +1
// ====================

`timescale 1ns/1ns

module ternary_trit_decoder (
    input  logic [7:0]                packed_weights,
    output ternary_pkg::trit_group_t  weights
);

    // remaining quotient and the digit peeled off in each step
    logic [7:0] rest;
    logic [1:0] digit;

    always_comb begin
        rest = packed_weights;
        digit = '0;
        weights = '0;

        // least significant digit first, it lands in the top weight bit
        for (int k = 0; k < ternary_pkg::trits_per_byte; k++) begin
            digit = 2'(rest % 8'd3);
            rest = rest / 8'd3;
            weights.zero[ternary_pkg::trits_per_byte-1-k] = (digit == 2'd0);
            weights.sign[ternary_pkg::trits_per_byte-1-k] = (digit == 2'd2);
        end

        // out of range codes: no zeros and no negatives, i.e. all +1
        if (int'(packed_weights) >= 3 ** ternary_pkg::trits_per_byte) begin
            weights.zero = '0;
            weights.sign = '0;
        end
    end

endmodule

// File: design/operand_staging.sv
// ====================
// collects four cycles of decoded weights and activations into one group
// and freezes the completed group for the array while the next one fills
// ====================

`timescale 1ns/1ns

module operand_staging (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      restart,
    input  ternary_pkg::trit_group_t  group,
    input  logic [7:0]                activation,
    output ternary_pkg::slice_idx_t   slice,
    output ternary_pkg::weight_vec_t  weights,
    output ternary_pkg::act_vec_t     acts
);

    // buffers being filled, one slot per slice
    ternary_pkg::weight_vec_t collect_weights;
    ternary_pkg::act_vec_t    collect_acts;

    // slice counter, wraps naturally at 3
    always_ff @(posedge clk) begin
        if (reset || restart) begin
            slice <= '0;
        end else begin
            slice <= slice + 1'b1;
        end
    end

    // slot s takes rows 5s..5s+4 and column s
    always_ff @(posedge clk) begin
        if (reset) begin
            collect_weights <= '0;
            collect_acts <= '0;
        end else begin
            collect_weights.zero[slice*ternary_pkg::trits_per_byte +: ternary_pkg::trits_per_byte]
                <= group.zero;
            collect_weights.sign[slice*ternary_pkg::trits_per_byte +: ternary_pkg::trits_per_byte]
                <= group.sign;
            collect_acts[slice] <= activation;
        end
    end

    // hand the finished group over at the start of a new one
    // slot 0 of the next group is written at this same edge
    always_ff @(posedge clk) begin
        if (reset) begin
            weights <= '0;
            acts <= '0;
        end else if (slice == '0) begin
            weights <= collect_weights;
            acts <= collect_acts;
        end
    end

endmodule

// File: design/mac_array.sv
// ====================
// 20 x 4 grid of signed accumulators, one column updated per cycle
// each cell adds, subtracts or holds the frozen activation of its column
// ====================

`timescale 1ns/1ns

module mac_array (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      clear,
    input  ternary_pkg::slice_idx_t   slice,
    input  ternary_pkg::weight_vec_t  weights,
    input  ternary_pkg::act_vec_t     acts,
    output ternary_pkg::acc_t         next_values [ternary_pkg::cells]
);

    ternary_pkg::acc_t acc [ternary_pkg::cells];

    // cell (i, j) sits at entry i*cols + j
    for (genvar i = 0; i < ternary_pkg::rows; i++) begin : g_row
        for (genvar j = 0; j < ternary_pkg::cols; j++) begin : g_col
            localparam int idx = i * ternary_pkg::cols + j;

            logic              skip;
            ternary_pkg::acc_t addend;

            // only the active column moves, and only for nonzero weights
            assign skip = (slice != ternary_pkg::slice_idx_t'(j)) || weights.zero[i];

            // sign-extend the activation to accumulator width
            assign addend = ternary_pkg::acc_t'($signed(acts[j]));

            assign next_values[idx] = skip            ? acc[idx] :
                                      weights.sign[i] ? acc[idx] - addend :
                                                        acc[idx] + addend;
        end
    end

    always_ff @(posedge clk) begin
        for (int n = 0; n < ternary_pkg::cells; n++) begin
            if (reset || clear) begin
                acc[n] <= '0;
            end else begin
                acc[n] <= next_values[n];
            end
        end
    end

endmodule

// File: design/result_queue.sv
// ====================
// snapshot of all accumulators, streamed out one entry per cycle
// result is bits 15:8 of the entry under the wrapping read index
// ====================

`timescale 1ns/1ns

module result_queue (
    input  logic               clk,
    input  logic               reset,
    input  logic               snapshot,
    input  ternary_pkg::acc_t  next_values [ternary_pkg::cells],
    output logic [7:0]         result
);

    ternary_pkg::acc_t     entries [ternary_pkg::cells];
    ternary_pkg::cell_idx_t index;

    // captured values include the update made in the snapshot cycle
    always_ff @(posedge clk) begin
        for (int n = 0; n < ternary_pkg::cells; n++) begin
            if (reset) begin
                entries[n] <= '0;
            end else if (snapshot) begin
                entries[n] <= next_values[n];
            end
        end
    end

    // read index, restarts at the snapshot and wraps after the last cell
    always_ff @(posedge clk) begin
        if (reset || snapshot) begin
            index <= '0;
        end else if (index == ternary_pkg::cell_idx_t'(ternary_pkg::cells - 1)) begin
            index <= '0;
        end else begin
            index <= index + 1'b1;
        end
    end

    assign result = entries[index][ternary_pkg::out_shift +: 8];

endmodule

// File: design/ternary_matmul_top.sv
// ====================
// ternary-weight matrix-multiply engine
// feed one weight code and one activation per cycle; pull compute_enable
// low for one cycle to snapshot, clear and start streaming results
// ====================

`timescale 1ns/1ns

module ternary_matmul_top (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] packed_weights,
    input  logic [7:0] activation,
    input  logic       compute_enable,
    output logic [7:0] result
);

    logic                     restart;
    ternary_pkg::trit_group_t group;
    ternary_pkg::slice_idx_t  slice;
    ternary_pkg::weight_vec_t weights;
    ternary_pkg::act_vec_t    acts;
    ternary_pkg::acc_t        next_values [ternary_pkg::cells];

    // readout strobe: restart staging, clear the array and snapshot in one cycle
    assign restart = !compute_enable;

    ternary_trit_decoder i_ternary_trit_decoder (
        .packed_weights (packed_weights),
        .weights        (group)
    );

    operand_staging i_operand_staging (
        .clk        (clk),
        .reset      (reset),
        .restart    (restart),
        .group      (group),
        .activation (activation),
        .slice      (slice),
        .weights    (weights),
        .acts       (acts)
    );

    mac_array i_mac_array (
        .clk         (clk),
        .reset       (reset),
        .clear       (restart),
        .slice       (slice),
        .weights     (weights),
        .acts        (acts),
        .next_values (next_values)
    );

    result_queue i_result_queue (
        .clk         (clk),
        .reset       (reset),
        .snapshot    (restart),
        .next_values (next_values),
        .result      (result)
    );

endmodule

// File: bench/ternary_matmul_assertions.sv
// ====================
// concurrent checks on the matmul top level, attached by bind
// covers the reset value of result and the readout index wrap
// ====================

`timescale 1ns/1ns

module ternary_matmul_assertions (
    input logic                   clk,
    input logic                   reset,
    input logic                   compute_enable,
    input logic [7:0]             result,
    input ternary_pkg::cell_idx_t index
);

    // cycles since the index last sat at entry 0
    logic [6:0] since_zero;

    always_ff @(posedge clk) begin
        if (reset || index == '0) begin
            since_zero <= '0;
        end else begin
            since_zero <= since_zero + 1'b1;
        end
    end

    a_reset_result: assert property (@(posedge clk) reset |=> (result == 8'h00))
        else $error("result not zero after reset");

    a_restart_index: assert property (@(posedge clk) disable iff (reset)
        !compute_enable |=> (index == '0))
        else $error("index not at entry 0 after restart");

    a_index_wrap: assert property (@(posedge clk) disable iff (reset)
        since_zero <= 7'(ternary_pkg::cells - 1))
        else $error("index did not wrap within one pass over the queue");

endmodule

bind ternary_matmul_top ternary_matmul_assertions i_ternary_matmul_assertions (
    .clk            (clk),
    .reset          (reset),
    .compute_enable (compute_enable),
    .result         (result),
    .index          (i_result_queue.index)
);

// File: bench/ternary_matmul_tb.sv
// ====================
// testbench for the ternary matmul engine
// drives directed and random codes, mirrors the design in a cycle model
// and compares every streamed result byte against it
// ====================

`timescale 1ns/1ns

module ternary_matmul_tb;

    localparam int clk_period = 8;
    localparam int reset_cycles = 10;
    localparam int idle_cycles = 100;
    localparam int stream_cycles = ternary_pkg::cells;
    localparam int group_cycles = ternary_pkg::slices;
    localparam int decode_codes = 10;
    localparam int random_groups = 40;
    localparam int clear_groups = 8;
    localparam int partial_groups = 3;

    // test lengths in cycles for sizing the watchdog
    localparam int decode_cycles = decode_codes * (2 * group_cycles + 1 + stream_cycles);
    localparam int random_cycles = (random_groups + 1) * group_cycles + 1 + stream_cycles;
    localparam int clear_cycles = clear_groups * group_cycles + 2 + stream_cycles;
    localparam int partial_cycles = partial_groups * group_cycles + 4 + stream_cycles;
    localparam int total_cycles = reset_cycles + idle_cycles + decode_cycles
                                + random_cycles + clear_cycles + partial_cycles;
    localparam int watchdog_ns = (total_cycles + 50) * clk_period;

    logic       clk;
    logic       reset;
    logic [7:0] packed_weights;
    logic [7:0] activation;
    logic       compute_enable;
    logic [7:0] result;

    int seed = 76590;
    int errors = 0;
    int checks = 0;
    bit checking = 1'b0;
    bit expect_zero = 1'b0;

    // cycle model of staging, array and queue
    int                           m_slice;
    logic [ternary_pkg::rows-1:0] m_collect_zero;
    logic [ternary_pkg::rows-1:0] m_collect_sign;
    logic [ternary_pkg::rows-1:0] m_frozen_zero;
    logic [ternary_pkg::rows-1:0] m_frozen_sign;
    int                           m_collect_act [ternary_pkg::cols];
    int                           m_frozen_act [ternary_pkg::cols];
    int                           m_acc [ternary_pkg::cells];
    int                           m_entries [ternary_pkg::cells];
    int                           m_index;

    ternary_matmul_top i_ternary_matmul_top (
        .clk            (clk),
        .reset          (reset),
        .packed_weights (packed_weights),
        .activation     (activation),
        .compute_enable (compute_enable),
        .result         (result)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // digit k of the code is (code / 3^k) mod 3 and sets weight bit 4-k
    function automatic void decode_code(input logic [7:0] code, output logic [4:0] zero,
                                        output logic [4:0] sign);
        int value;
        int digit;
        value = int'(code);
        zero = '0;
        sign = '0;
        if (value > 242) begin
            return;
        end
        for (int k = 0; k < 5; k++) begin
            digit = (value / (3 ** k)) % 3;
            zero[4-k] = (digit == 0);
            sign[4-k] = (digit == 2);
        end
    endfunction

    function automatic logic [7:0] random_byte();
        return 8'($random(seed));
    endfunction

    // about one code in eight is pushed past 242
    function automatic logic [7:0] random_code();
        logic [7:0] code;
        code = 8'($random(seed));
        if (code[2:0] == 3'd0) begin
            code = 8'd243 + 8'(code[7:3] % 5'd13);
        end
        return code;
    endfunction

    // bits 15:8 of one model queue entry
    function automatic logic [7:0] entry_byte(input int n);
        logic [31:0] word;
        word = 32'(m_entries[n]);
        return word[15:8];
    endfunction

    function automatic logic [7:0] expected_result();
        return entry_byte(m_index);
    endfunction

    task automatic check_value(input logic [7:0] actual, input logic [7:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] time %0t: %s, got 0x%02h, expected 0x%02h",
                     $time, what, actual, expected);
        end
    endtask

    // advance the model by one clock edge using the inputs held before it
    task automatic model_edge();
        int         nxt [ternary_pkg::cells];
        int         row;
        int         col;
        logic [4:0] zero;
        logic [4:0] sign;
        for (int n = 0; n < ternary_pkg::cells; n++) begin
            row = n / ternary_pkg::cols;
            col = n % ternary_pkg::cols;
            nxt[n] = m_acc[n];
            if (col == m_slice && !m_frozen_zero[row]) begin
                if (m_frozen_sign[row]) begin
                    nxt[n] = m_acc[n] - m_frozen_act[col];
                end else begin
                    nxt[n] = m_acc[n] + m_frozen_act[col];
                end
            end
        end
        if (reset) begin
            m_slice = 0;
            m_index = 0;
            m_collect_zero = '0;
            m_collect_sign = '0;
            m_frozen_zero = '0;
            m_frozen_sign = '0;
            for (int n = 0; n < ternary_pkg::cells; n++) begin
                m_acc[n] = 0;
                m_entries[n] = 0;
            end
            for (int c = 0; c < ternary_pkg::cols; c++) begin
                m_collect_act[c] = 0;
                m_frozen_act[c] = 0;
            end
        end else begin
            decode_code(packed_weights, zero, sign);
            if (!compute_enable) begin
                m_entries = nxt;
                m_index = 0;
            end else begin
                m_index = (m_index == ternary_pkg::cells - 1) ? 0 : m_index + 1;
            end
            for (int n = 0; n < ternary_pkg::cells; n++) begin
                m_acc[n] = compute_enable ? nxt[n] : 0;
            end
            // freeze before the current slot is overwritten
            if (m_slice == 0) begin
                m_frozen_zero = m_collect_zero;
                m_frozen_sign = m_collect_sign;
                m_frozen_act = m_collect_act;
            end
            for (int b = 0; b < 5; b++) begin
                m_collect_zero[m_slice * 5 + b] = zero[b];
                m_collect_sign[m_slice * 5 + b] = sign[b];
            end
            m_collect_act[m_slice] = int'($signed(activation));
            m_slice = compute_enable ? (m_slice + 1) % ternary_pkg::slices : 0;
        end
    endtask

    task automatic step(input logic [7:0] code, input logic [7:0] act, input logic enable,
                        input logic rst);
        @(posedge clk);
        model_edge();
        packed_weights <= code;
        activation <= act;
        compute_enable <= enable;
        reset <= rst;
    endtask

    // low strobe for low_cycles followed by one full pass over the queue
    task automatic stream_readout(input int low_cycles, input bit random_fill);
        for (int n = 0; n < low_cycles + stream_cycles; n++) begin
            if (random_fill) begin
                step(random_code(), random_byte(), n >= low_cycles, 1'b0);
            end else begin
                step(8'd0, 8'd0, n >= low_cycles, 1'b0);
            end
        end
    endtask

    always @(negedge clk) begin
        if (checking) begin
            check_value(result, expected_result(), $sformatf("result at index %0d", m_index));
            if (expect_zero) begin
                check_value(result, 8'h00, "idle result");
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog: run did not finish within %0d ns", watchdog_ns);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        logic [7:0] code;
        logic [7:0] first_byte;
        logic [7:0] wrapped_byte;

        reset = 1'b1;
        packed_weights = '0;
        activation = '0;
        compute_enable = 1'b1;
        repeat (reset_cycles - 1) step(8'd0, 8'd0, 1'b1, 1'b1);
        step(8'd0, 8'd0, 1'b1, 1'b0);
        checking = 1'b1;

        // idle after reset
        expect_zero = 1'b1;
        repeat (idle_cycles) step(8'd0, 8'd0, 1'b1, 1'b0);
        expect_zero = 1'b0;

        // one nonzero digit per code with columns alternating +127 and -128
        for (int k = 0; k < ternary_pkg::trits_per_byte; k++) begin
            for (int m = 1; m <= 2; m++) begin
                code = 8'(m * (3 ** k));
                for (int s = 0; s < group_cycles; s++) begin
                    step(code, (s % 2 == 0) ? 8'h7f : 8'h80, 1'b1, 1'b0);
                end
                repeat (group_cycles) step(8'd0, 8'd0, 1'b1, 1'b0);
                stream_readout(1, 1'b0);
            end
        end

        // random accumulation over many groups
        repeat ((random_groups + 1) * group_cycles) step(random_code(), random_byte(), 1'b1, 1'b0);
        stream_readout(1, 1'b1);

        // back to back strobes so the second snapshot holds one cycle of updates
        repeat (clear_groups * group_cycles) step(random_code(), random_byte(), 1'b1, 1'b0);
        stream_readout(2, 1'b1);

        // strobe in the middle of a group and watch the index wrap
        repeat (partial_groups * group_cycles + 2) begin
            step(random_code(), random_byte(), 1'b1, 1'b0);
        end
        step(random_code(), random_byte(), 1'b0, 1'b0);
        step(random_code(), random_byte(), 1'b1, 1'b0);
        @(negedge clk);
        first_byte = result;
        check_value(first_byte, entry_byte(0), "entry 0 right after restart");
        repeat (stream_cycles) step(random_code(), random_byte(), 1'b1, 1'b0);
        @(negedge clk);
        wrapped_byte = result;
        check_value(wrapped_byte, entry_byte(0), "entry 0 after index wrap");

        #1;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: files.f
design/ternary_pkg.sv
design/ternary_trit_decoder.sv
design/operand_staging.sv
design/mac_array.sv
design/result_queue.sv
design/ternary_matmul_top.sv
bench/ternary_matmul_assertions.sv
bench/ternary_matmul_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the ternary matmul testbench with Verilator
# exits with 0 only when the log holds the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module ternary_matmul_tb -f files.f -o tb_sim \
    || { echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -qF "*** TEST PASSED ***" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
